// ==== build.f ====
+incdir+include
rtl/mipsIsaPkg.sv
rtl/mipsCtrlPkg.sv
rtl/mainDecoder.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/programCounter.sv
rtl/singleCycleCore.sv
testbench/singleCycleCoreTb.sv

// ==== testbench/singleCycleCoreTb.sv ====
`timescale 1ns/1ps
`include "mipsDefines_defines.svh"

module singleCycleCoreTb;

  localparam int NUM_TESTS = 5;
  localparam int MAX_CYCLES = 200;
  // spin loop that ends the program
  localparam int END_INDEX = 32;

  logic                        clk;
  logic                        rst;
  logic [`DATA_WIDTH-1:0]      irAddr;
  logic [`DATA_WIDTH-1:0]      ir;
  logic [`DMEM_ADDR_WIDTH-1:0] memAddr;
  logic [`DATA_WIDTH-1:0]      memWriteData;
  logic [`DATA_WIDTH-1:0]      memReadData;
  logic                        memCen;
  logic                        memWen;
  logic [`DATA_WIDTH-1:0]      rfWriteData;

  // memories seen by the dut
  logic [`DATA_WIDTH-1:0] imem [64];
  logic [`DATA_WIDTH-1:0] dmem [128];
  // architectural copy for the reference model
  logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
  logic [`DATA_WIDTH-1:0] modelMem [128];
  logic [`DATA_WIDTH-1:0] modelPc;

  integer seed;
  logic runActive;
  int currentTest;
  int testErrors;
  int errorCount;
  int passCount;
  int failCount;

  singleCycleCore dut (
    .clk(clk), .rst(rst),
    .irAddr(irAddr), .ir(ir),
    .memAddr(memAddr), .memWriteData(memWriteData), .memReadData(memReadData),
    .memCen(memCen), .memWen(memWen),
    .rfWriteData(rfWriteData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ======================================================================
  // memory models
  // ======================================================================

  // instruction fetch by word index
  assign ir = imem[irAddr[7:2]];
  // combinational read while selected for a load
  assign memReadData = (!memCen && memWen) ? dmem[memAddr] : '0;

  always @(posedge clk) begin
    if (!memCen && !memWen) begin
      dmem[memAddr] <= memWriteData;
    end
  end

  // ======================================================================
  // encoders, names and reporting
  // ======================================================================

  function automatic logic [31:0] rType(logic [5:0] f, logic [4:0] s, logic [4:0] t,
                                        logic [4:0] d);
    return {6'b000000, s, t, d, 5'b00000, f};
  endfunction

  function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] s, logic [4:0] t,
                                        logic [15:0] imm);
    return {op, s, t, imm};
  endfunction

  function automatic logic [31:0] jType(logic [5:0] op, logic [25:0] target);
    return {op, target};
  endfunction

  function automatic string testName(int idx);
    case (idx)
      0:       return "loadsArith";
      1:       return "stores";
      2:       return "branches";
      3:       return "jumps";
      default: return "zeroReg";
    endcase
  endfunction

  // first instruction index of each slice and finally the end address
  function automatic int segStart(int idx);
    case (idx)
      1:       return 12;
      2:       return 17;
      3:       return 24;
      4:       return 29;
      default: return END_INDEX;
    endcase
  endfunction

  task automatic reportValue(string name, string what, logic [31:0] expVal,
                             logic [31:0] actVal);
    $display("Error %s %s: expected %h, actual %h", name, what, expVal, actVal);
    testErrors = testErrors + 1;
    errorCount = errorCount + 1;
  endtask

  task automatic finishTest(string name);
    if (testErrors == 0) begin
      passCount = passCount + 1;
      $display("test %s: ok", name);
    end else begin
      failCount = failCount + 1;
      $display("test %s: %0d wrong values", name, testErrors);
    end
    testErrors = 0;
  endtask

  // ======================================================================
  // program
  // ======================================================================

  task automatic loadProgram();
    // loads with a negative word at 12 and a positive one at 16
    imem[0]  = iType(mipsIsaPkg::OP_LW, 0, 1, 0);
    imem[1]  = iType(mipsIsaPkg::OP_LW, 0, 2, 4);
    imem[2]  = iType(mipsIsaPkg::OP_LW, 0, 3, 8);
    imem[3]  = iType(mipsIsaPkg::OP_LW, 0, 10, 12);
    imem[4]  = iType(mipsIsaPkg::OP_LW, 0, 11, 16);
    imem[5]  = rType(mipsIsaPkg::FN_ADD, 1, 2, 4);
    imem[6]  = rType(mipsIsaPkg::FN_SUB, 1, 2, 5);
    imem[7]  = rType(mipsIsaPkg::FN_AND, 1, 3, 6);
    imem[8]  = rType(mipsIsaPkg::FN_OR, 2, 3, 7);
    imem[9]  = rType(mipsIsaPkg::FN_SLT, 1, 2, 8);
    imem[10] = rType(mipsIsaPkg::FN_SLT, 11, 10, 12);
    imem[11] = rType(mipsIsaPkg::FN_SLT, 10, 11, 13);
    // stores including one at a random base and their read back
    imem[12] = iType(mipsIsaPkg::OP_SW, 0, 4, 40);
    imem[13] = iType(mipsIsaPkg::OP_SW, 0, 12, 44);
    imem[14] = iType(mipsIsaPkg::OP_SW, 1, 11, 4);
    imem[15] = iType(mipsIsaPkg::OP_LW, 0, 15, 40);
    imem[16] = iType(mipsIsaPkg::OP_LW, 1, 16, 4);
    // taken forward, not taken, then a forward/backward hop
    imem[17] = iType(mipsIsaPkg::OP_BEQ, 1, 1, 16'd2);
    imem[18] = rType(mipsIsaPkg::FN_ADD, 1, 1, 20);
    imem[19] = rType(mipsIsaPkg::FN_ADD, 2, 2, 20);
    imem[20] = iType(mipsIsaPkg::OP_BEQ, 1, 2, 16'd1);
    imem[21] = iType(mipsIsaPkg::OP_BEQ, 0, 0, 16'd1);
    imem[22] = iType(mipsIsaPkg::OP_BEQ, 0, 0, 16'd1);
    imem[23] = iType(mipsIsaPkg::OP_BEQ, 0, 0, 16'hFFFE);
    // j and jal each skip a word and an add shows the link
    imem[24] = jType(mipsIsaPkg::OP_J, 26'd26);
    imem[25] = rType(mipsIsaPkg::FN_ADD, 1, 1, 21);
    imem[26] = jType(mipsIsaPkg::OP_JAL, 26'd28);
    imem[27] = rType(mipsIsaPkg::FN_ADD, 2, 2, 21);
    imem[28] = rType(mipsIsaPkg::FN_ADD, 31, 0, 17);
    // $zero as destination and as source
    imem[29] = rType(mipsIsaPkg::FN_ADD, 1, 2, 0);
    imem[30] = rType(mipsIsaPkg::FN_ADD, 0, 3, 18);
    imem[31] = rType(mipsIsaPkg::FN_ADD, 3, 0, 19);
    imem[END_INDEX] = iType(mipsIsaPkg::OP_BEQ, 0, 0, 16'hFFFF);
  endtask

  // ======================================================================
  // reference model
  // ======================================================================

  function automatic void refStep(input logic [31:0] instr, input logic [31:0] pcIn,
                                  output logic [31:0] nextPc, output logic wr,
                                  output logic [4:0] wrAddr, output logic [31:0] wrVal,
                                  output logic cen, output logic wen,
                                  output logic [6:0] addr, output logic [31:0] wdata);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] seImm;
    logic [31:0] byteAddr;
    a = modelRegs[instr[25:21]];
    b = modelRegs[instr[20:16]];
    seImm = {{16{instr[15]}}, instr[15:0]};
    byteAddr = a + seImm;
    nextPc = pcIn + 32'd4;
    wr = 1'b0;
    wrAddr = '0;
    wrVal = '0;
    cen = 1'b1;
    wen = 1'b1;
    addr = '0;
    wdata = '0;
    case (instr[31:26])
      mipsIsaPkg::OP_RTYPE: begin
        wr = 1'b1;
        wrAddr = instr[15:11];
        case (instr[5:0])
          mipsIsaPkg::FN_ADD: wrVal = a + b;
          mipsIsaPkg::FN_SUB: wrVal = a - b;
          mipsIsaPkg::FN_AND: wrVal = a & b;
          mipsIsaPkg::FN_OR:  wrVal = a | b;
          mipsIsaPkg::FN_SLT: wrVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default:            wrVal = '0;
        endcase
      end
      mipsIsaPkg::OP_LW: begin
        cen = 1'b0;
        addr = byteAddr[8:2];
        wr = 1'b1;
        wrAddr = instr[20:16];
        wrVal = modelMem[byteAddr[8:2]];
      end
      mipsIsaPkg::OP_SW: begin
        cen = 1'b0;
        wen = 1'b0;
        addr = byteAddr[8:2];
        wdata = b;
      end
      mipsIsaPkg::OP_BEQ: begin
        if (a == b) begin
          nextPc = pcIn + 32'd4 + {seImm[29:0], 2'b00};
        end
      end
      mipsIsaPkg::OP_J: begin
        nextPc = {nextPc[31:28], instr[25:0], 2'b00};
      end
      mipsIsaPkg::OP_JAL: begin
        wr = 1'b1;
        wrAddr = mipsIsaPkg::LINK_REG;
        wrVal = pcIn + 32'd4;
        nextPc = {nextPc[31:28], instr[25:0], 2'b00};
      end
      default: begin
        // no-op, pc advances
      end
    endcase
  endfunction

  // ======================================================================
  // compare one instruction per falling edge
  // ======================================================================

  always @(negedge clk) begin : compareProc
    logic [31:0] instr;
    logic [31:0] nextPc;
    logic        wr;
    logic [4:0]  wrAddr;
    logic [31:0] wrVal;
    logic        cen;
    logic        wen;
    logic [6:0]  addr;
    logic [31:0] wdata;
    // slice ends once the model pc enters the next one
    if (runActive && currentTest < NUM_TESTS) begin
      if (modelPc[31:2] >= segStart(currentTest + 1)) begin
        finishTest(testName(currentTest));
        currentTest = currentTest + 1;
      end
    end
    if (runActive && currentTest < NUM_TESTS) begin
      instr = imem[modelPc[7:2]];
      refStep(instr, modelPc, nextPc, wr, wrAddr, wrVal, cen, wen, addr, wdata);
      if (irAddr !== modelPc) begin
        reportValue(testName(currentTest), "irAddr", modelPc, irAddr);
      end
      if (wr && rfWriteData !== wrVal) begin
        reportValue(testName(currentTest), "rfWriteData", wrVal, rfWriteData);
      end
      if (memCen !== cen) begin
        reportValue(testName(currentTest), "memCen", {31'b0, cen}, {31'b0, memCen});
      end
      if (memWen !== wen) begin
        reportValue(testName(currentTest), "memWen", {31'b0, wen}, {31'b0, memWen});
      end
      if (!cen && memAddr !== addr) begin
        reportValue(testName(currentTest), "memAddr", {25'b0, addr}, {25'b0, memAddr});
      end
      if (!wen && memWriteData !== wdata) begin
        reportValue(testName(currentTest), "memWriteData", wdata, memWriteData);
      end
      // commit model state while $zero stays zero
      if (wr && wrAddr != 5'd0) begin
        modelRegs[wrAddr] = wrVal;
      end
      if (!wen) begin
        modelMem[addr] = wdata;
      end
      modelPc = nextPc;
    end
  end

  // ======================================================================
  // main sequence
  // ======================================================================

  initial begin : mainProc
    int cycles;
    rst = 1'b0;
    runActive = 1'b0;
    currentTest = 0;
    testErrors = 0;
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    modelPc = '0;
    seed = 32'h9c44cde8;
    for (int i = 0; i < 128; i++) begin
      dmem[i] = $random(seed);
    end
    // one negative and one positive operand for slt
    dmem[3] = 32'hFFFF_FFF0;
    dmem[4] = 32'h7FFF_0005;
    for (int i = 0; i < 128; i++) begin
      modelMem[i] = dmem[i];
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
      modelRegs[i] = '0;
    end
    loadProgram();
    // reset held for 8 cycles
    repeat (7) begin
      @(negedge clk);
      if (irAddr !== 32'd0) begin
        reportValue("reset", "irAddr", 32'd0, irAddr);
      end
      if (memWen !== 1'b1) begin
        reportValue("reset", "memWen", 32'd1, {31'b0, memWen});
      end
    end
    @(posedge clk);
    finishTest("reset");
    runActive = 1'b1;
    @(negedge clk);
    rst = 1'b1;
    cycles = 0;
    while (currentTest < NUM_TESTS && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    if (currentTest < NUM_TESTS) begin
      $display("program never reached its end address within %0d cycles", MAX_CYCLES);
      errorCount = errorCount + 1;
      failCount = failCount + 1;
    end
    $display("tests passed %0d, failed %0d", passCount, failCount);
    if (errorCount == 0 && failCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/singleCycleCore.sv ====
`timescale 1ns/1ps
`include "mipsDefines_defines.svh"

module singleCycleCore (
  input  logic                       clk,
  input  logic                       rst,
  // instruction memory
  output logic [`DATA_WIDTH-1:0]     irAddr,
  input  logic [`DATA_WIDTH-1:0]     ir,
  // data memory
  output logic [`DMEM_ADDR_WIDTH-1:0] memAddr,
  output logic [`DATA_WIDTH-1:0]     memWriteData,
  input  logic [`DATA_WIDTH-1:0]     memReadData,
  output logic                       memCen,
  output logic                       memWen,
  // register write path, observation only
  output logic [`DATA_WIDTH-1:0]     rfWriteData
);

  // instruction fields
  mipsIsaPkg::opcodeT          opcode;
  mipsIsaPkg::functT           funct;
  logic [`REG_ADDR_WIDTH-1:0]  rs;
  logic [`REG_ADDR_WIDTH-1:0]  rt;
  logic [`REG_ADDR_WIDTH-1:0]  rd;
  logic [15:0]                 imm;
  logic [25:0]                 target;
  logic [`DATA_WIDTH-1:0]      signExtImm;
  // control
  logic                        regDst;
  logic                        aluSrc;
  logic                        memToReg;
  logic                        regWrite;
  logic                        memRead;
  logic                        memWrite;
  logic                        branch;
  logic                        jump;
  logic                        link;
  mipsCtrlPkg::aluOpT          aluOp;
  // datapath
  logic [`DATA_WIDTH-1:0]      pc;
  logic [`DATA_WIDTH-1:0]      pcPlus4;
  logic [`DATA_WIDTH-1:0]      readData1;
  logic [`DATA_WIDTH-1:0]      readData2;
  logic [`DATA_WIDTH-1:0]      aluB;
  logic [`DATA_WIDTH-1:0]      aluResult;
  logic                        aluZero;
  logic [`REG_ADDR_WIDTH-1:0]  writeAddr;
  logic [`DATA_WIDTH-1:0]      writeData;

  // ======================================================================
  // instruction split and immediate
  // ======================================================================

  assign opcode = mipsIsaPkg::opcodeT'(ir[31:26]);
  assign funct  = mipsIsaPkg::functT'(ir[5:0]);
  assign rs     = ir[25:21];
  assign rt     = ir[20:16];
  assign rd     = ir[15:11];
  assign imm    = ir[15:0];
  assign target = ir[25:0];
  // sign extension for lw/sw offset and beq
  assign signExtImm = {{(`DATA_WIDTH-16){imm[15]}}, imm};

  // ======================================================================
  // blocks
  // ======================================================================

  programCounter uPc (
    .clk(clk), .rst(rst),
    .branch(branch), .zero(aluZero), .jump(jump),
    .branchOffset(signExtImm), .jumpTarget(target),
    .pc(pc), .pcPlus4(pcPlus4)
  );

  mainDecoder uDecoder (
    .opcode(opcode),
    .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
    .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
    .branch(branch), .jump(jump), .link(link), .aluOp(aluOp)
  );

  registerFile uRegs (
    .clk(clk), .rst(rst),
    .writeEnable(regWrite),
    .readAddr1(rs), .readAddr2(rt), .writeAddr(writeAddr),
    .writeData(writeData),
    .readData1(readData1), .readData2(readData2)
  );

  alu uAlu (
    .aluOp(aluOp), .funct(funct),
    .a(readData1), .b(aluB),
    .result(aluResult), .zero(aluZero)
  );

  // ======================================================================
  // operand, destination and write-back selection
  // ======================================================================

  // immediate for lw/sw, rt otherwise
  assign aluB = aluSrc ? signExtImm : readData2;
  // jal goes to $ra, r-format to rd, loads to rt
  assign writeAddr = link ? mipsIsaPkg::LINK_REG : (regDst ? rd : rt);
  // no delay slot so jal links pc + 4
  assign writeData = link ? pcPlus4 : (memToReg ? memReadData : aluResult);

  // ======================================================================
  // outside ports
  // ======================================================================

  assign irAddr = pc;
  assign rfWriteData = writeData;
  // byte address to word address
  assign memAddr = aluResult[`DMEM_ADDR_WIDTH+1:2];
  assign memWriteData = readData2;
  // active low strobes, enabled only for lw and sw
  assign memCen = ~(memRead | memWrite);
  assign memWen = ~memWrite;

endmodule

// ==== rtl/programCounter.sv ====
`timescale 1ns/1ps
`include "mipsDefines_defines.svh"

module programCounter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   branch,
  input  logic                   zero,
  input  logic                   jump,
  input  logic [`DATA_WIDTH-1:0] branchOffset,
  input  logic [25:0]            jumpTarget,
  output logic [`DATA_WIDTH-1:0] pc,
  output logic [`DATA_WIDTH-1:0] pcPlus4
);

  logic [`DATA_WIDTH-1:0] branchAddr;
  logic [`DATA_WIDTH-1:0] jumpAddr;
  logic [`DATA_WIDTH-1:0] pcNext;

  // ======================================================================
  // next pc candidates
  // ======================================================================

  // sequential, no delay slot
  assign pcPlus4 = pc + `DATA_WIDTH'd4;
  // word offset relative to the following instruction
  assign branchAddr = pcPlus4 + {branchOffset[`DATA_WIDTH-3:0], 2'b00};
  // pseudo-direct, region bits from pc + 4
  assign jumpAddr = {pcPlus4[`DATA_WIDTH-1 -: 4], jumpTarget, 2'b00};

  // jump has priority, then a taken beq
  always_comb begin
    if (jump) begin
      pcNext = jumpAddr;
    end else if (branch && zero) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ======================================================================
  // pc register
  // ======================================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps
`include "mipsDefines_defines.svh"

module registerFile (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       writeEnable,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddr1,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddr2,
  input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
  input  logic [`DATA_WIDTH-1:0]     writeData,
  output logic [`DATA_WIDTH-1:0]     readData1,
  output logic [`DATA_WIDTH-1:0]     readData2
);

  // general purpose registers
  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  // ======================================================================
  // write port
  // ======================================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // clear every entry
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeAddr != '0)) begin
      // $zero is never written
      regs[writeAddr] <= writeData;
    end
  end

  // ======================================================================
  // read ports
  // ======================================================================

  // combinational, register zero reads as zero
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`include "mipsDefines_defines.svh"

module alu (
  input  mipsCtrlPkg::aluOpT     aluOp,
  input  mipsIsaPkg::functT      funct,
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  output logic [`DATA_WIDTH-1:0] result,
  output logic                   zero
);

  mipsCtrlPkg::aluFuncT aluFunc;

  // ======================================================================
  // second level decode
  // ======================================================================

  always_comb begin
    case (aluOp)
      // address calculation for lw and sw
      mipsCtrlPkg::ALUOP_ADD: aluFunc = mipsCtrlPkg::ALU_ADD;
      // compare for beq
      mipsCtrlPkg::ALUOP_SUB: aluFunc = mipsCtrlPkg::ALU_SUB;
      mipsCtrlPkg::ALUOP_FUNCT: begin
        // r-format, look at the function field
        case (funct)
          mipsIsaPkg::FN_ADD: aluFunc = mipsCtrlPkg::ALU_ADD;
          mipsIsaPkg::FN_SUB: aluFunc = mipsCtrlPkg::ALU_SUB;
          mipsIsaPkg::FN_AND: aluFunc = mipsCtrlPkg::ALU_AND;
          mipsIsaPkg::FN_OR:  aluFunc = mipsCtrlPkg::ALU_OR;
          mipsIsaPkg::FN_SLT: aluFunc = mipsCtrlPkg::ALU_SLT;
          default:            aluFunc = mipsCtrlPkg::ALU_INVALID;
        endcase
      end
      default: aluFunc = mipsCtrlPkg::ALU_INVALID;
    endcase
  end

  // ======================================================================
  // datapath
  // ======================================================================

  always_comb begin
    case (aluFunc)
      mipsCtrlPkg::ALU_ADD: result = a + b;
      mipsCtrlPkg::ALU_SUB: result = a - b;
      mipsCtrlPkg::ALU_AND: result = a & b;
      mipsCtrlPkg::ALU_OR:  result = a | b;
      // signed compare, result is 0 or 1
      mipsCtrlPkg::ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, ($signed(a) < $signed(b))};
      default:              result = '0;
    endcase
  end

  // flag on any operation, beq only looks at it after a subtract
  assign zero = (result == '0);

endmodule

// ==== rtl/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder (
  input  mipsIsaPkg::opcodeT  opcode,
  output logic                regDst,
  output logic                aluSrc,
  output logic                memToReg,
  output logic                regWrite,
  output logic                memRead,
  output logic                memWrite,
  output logic                branch,
  output logic                jump,
  output logic                link,
  output mipsCtrlPkg::aluOpT  aluOp
);

  // purely combinational opcode decode
  always_comb begin
    // defaults form a no-op that only advances pc
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluOp    = mipsCtrlPkg::ALUOP_ADD;
    case (opcode)
      mipsIsaPkg::OP_RTYPE: begin
        // rd <= rs op rt
        regDst   = 1'b1;
        regWrite = 1'b1;
        aluOp    = mipsCtrlPkg::ALUOP_FUNCT;
      end
      mipsIsaPkg::OP_LW: begin
        // rt <= mem[rs + imm]
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      mipsIsaPkg::OP_SW: begin
        // mem[rs + imm] <= rt
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsIsaPkg::OP_BEQ: begin
        // subtract rs - rt, zero flag picks the target
        branch = 1'b1;
        aluOp  = mipsCtrlPkg::ALUOP_SUB;
      end
      mipsIsaPkg::OP_J: begin
        jump = 1'b1;
      end
      mipsIsaPkg::OP_JAL: begin
        // jump and save pc + 4 in $ra
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        // unsupported opcode keeps the defaults
      end
    endcase
  end

endmodule

// ==== rtl/mipsCtrlPkg.sv ====
package mipsCtrlPkg;

  // ====================================================================
  // decoder to alu interface
  // ====================================================================

  // operation class from the main decoder
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'b00,
    ALUOP_SUB   = 2'b01,
    ALUOP_FUNCT = 2'b10
  } aluOpT;

  // internal alu function after the second decode level
  typedef enum logic [3:0] {
    ALU_AND     = 4'b0000,
    ALU_OR      = 4'b0001,
    ALU_ADD     = 4'b0010,
    ALU_SUB     = 4'b0110,
    ALU_SLT     = 4'b0111,
    ALU_INVALID = 4'b1111
  } aluFuncT;

endpackage

// ==== rtl/mipsIsaPkg.sv ====
`include "mipsDefines_defines.svh"

package mipsIsaPkg;

  // ====================================================================
  // instruction encodings of the supported subset
  // ====================================================================

  // primary opcode, ir[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_JAL   = 6'b000011,
    OP_BEQ   = 6'b000100,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcodeT;

  // r-format function field, ir[5:0]
  typedef enum logic [5:0] {
    FN_ADD = 6'b100000,
    FN_SUB = 6'b100010,
    FN_AND = 6'b100100,
    FN_OR  = 6'b100101,
    FN_SLT = 6'b101010
  } functT;

  // jal destination ($ra)
  localparam logic [`REG_ADDR_WIDTH-1:0] LINK_REG = `REG_ADDR_WIDTH'd31;

endpackage

// ==== include/mipsDefines_defines.svh ====
`ifndef MIPS_DEFINES_DEFINES_SVH
`define MIPS_DEFINES_DEFINES_SVH

// ======================================================================
// datapath sizing
// ======================================================================

// register, instruction, address and data width
`define DATA_WIDTH 32

// ======================================================================
// register file sizing
// ======================================================================

// number of general purpose registers
`define REG_COUNT 32
// index width for rs, rt, rd
`define REG_ADDR_WIDTH 5

// ======================================================================
// data memory port
// ======================================================================

// word address width on memAddr
`define DMEM_ADDR_WIDTH 7

`endif
